/* design/cart_pkg.sv */
package cart_pkg;

  // --------------------------------------------------
  // timing constants
  // --------------------------------------------------

  // memory cycle length, loaded when an access starts
  localparam logic [3:0] ROM_CYCLE_LEN = 4'd7;

  // cpu clock low this long means the console is off
  localparam logic [17:0] DEAD_TIMEOUT = 18'd96000;

  // sampling stages for address and data
  localparam int SYNC_DEPTH = 7;

  // --------------------------------------------------
  // basic types
  // --------------------------------------------------

  typedef logic [23:0] snes_addr_t;
  typedef logic [22:0] rom_addr_t;
  typedef logic [7:0]  byte_t;

  // psram word, high lane holds the even byte
  typedef struct packed {
    byte_t hi;
    byte_t lo;
  } rom_lanes_t;

  typedef union packed {
    logic [15:0] word;
    rom_lanes_t  lane;
  } rom_word_u;

  // filtered console bus
  typedef struct packed {
    snes_addr_t addr;
    byte_t      data;
    logic       read_n;
    logic       write_n;
    logic       cpu_clk;
    logic       romsel_n;
  } snes_bus_t;

  // raw sample histories, newest sample in bit 0
  typedef struct packed {
    logic [7:0] read_n;
    logic [7:0] write_n;
    logic [7:0] cpu_clk;
  } ctl_hist_t;

  typedef struct packed {
    logic rd_start;
    logic rd_end;
    logic wr_end;
    logic cycle_start;
    logic cycle_end;
    logic free_slot;
  } snes_strobe_t;

  // one pending access per requester
  typedef struct packed {
    logic       rd_pend;
    logic       wr_pend;
    logic       word;
    snes_addr_t addr;
    rom_word_u  wdata;
  } mem_req_t;

  typedef enum logic [8:0] {
    idle        = 9'b000000001,
    mcu_rd_addr = 9'b000000010,
    mcu_rd_end  = 9'b000000100,
    mcu_wr_addr = 9'b000001000,
    mcu_wr_end  = 9'b000010000,
    cop_rd_addr = 9'b000100000,
    cop_rd_end  = 9'b001000000,
    cop_wr_addr = 9'b010000000,
    cop_wr_end  = 9'b100000000
  } arb_state_t;

endpackage

/* design/snes_bus_sync.sv */
`timescale 1ns/1ps

module snes_bus_sync (
  input  logic                 CLK2,
  input  logic                 arst_n,
  input  cart_pkg::snes_addr_t snes_addr_in,
  input  cart_pkg::byte_t      snes_data_in,
  input  logic                 snes_read_n,
  input  logic                 snes_write_n,
  input  logic                 snes_cpu_clk,
  input  logic                 snes_romsel_n,
  output cart_pkg::snes_bus_t  bus,
  output cart_pkg::ctl_hist_t  ctl_hist
);
  import cart_pkg::*;

  logic [7:0] read_h;
  logic [7:0] write_h;
  logic [7:0] clk_h;
  logic [7:0] romsel_h;

  // address and data share one delay line
  logic [SYNC_DEPTH-1:0][31:0] ad_h;
  logic [31:0]                 ad_f;

  // control histories, idle levels after reset
  always_ff @(posedge CLK2 or negedge arst_n) begin
    if (!arst_n) begin
      read_h   <= '1;
      write_h  <= '1;
      clk_h    <= '0;
      romsel_h <= '1;
    end else begin
      read_h   <= {read_h[6:0], snes_read_n};
      write_h  <= {write_h[6:0], snes_write_n};
      clk_h    <= {clk_h[6:0], snes_cpu_clk};
      romsel_h <= {romsel_h[6:0], snes_romsel_n};
    end
  end

  always_ff @(posedge CLK2) begin
    ad_h <= {ad_h[SYNC_DEPTH-2:0], {snes_addr_in, snes_data_in}};
  end

  // two adjacent taps must agree to pass a high level
  assign ad_f = ad_h[SYNC_DEPTH-1] & ad_h[SYNC_DEPTH-2];

  assign bus = '{
    addr:     ad_f[31:8],
    data:     ad_f[7:0],
    read_n:   read_h[2] & read_h[1],
    write_n:  write_h[2] & write_h[1],
    cpu_clk:  clk_h[2] & clk_h[1],
    romsel_n: romsel_h[2] & romsel_h[1]
  };

  assign ctl_hist = '{read_n: read_h, write_n: write_h, cpu_clk: clk_h};

endmodule

/* design/snes_cycle_detect.sv */
`timescale 1ns/1ps

module snes_cycle_detect (
  input  logic                   CLK2,
  input  logic                   arst_n,
  input  cart_pkg::snes_bus_t    bus,
  input  cart_pkg::ctl_hist_t    ctl_hist,
  input  logic                   rom_hit,
  output cart_pkg::snes_strobe_t strb,
  output logic                   dead,
  output logic                   cop_reset
);
  import cart_pkg::*;

  logic        rd_start;
  logic        cycle_start;
  logic        cycle_end;
  logic        rd_end_q;
  logic        wr_end_q;
  logic        free_strobe;
  logic [17:0] dead_cnt;

  // --------------------------------------------------
  // edge patterns on the sample histories
  // --------------------------------------------------
  assign rd_start = ((ctl_hist.read_n[6:1] | ctl_hist.read_n[7:2]) == 6'b111100);
  assign cycle_start = ((ctl_hist.cpu_clk[7:2] & ctl_hist.cpu_clk[6:1]) == 6'b000011);
  assign cycle_end = ((ctl_hist.cpu_clk[7:2] | ctl_hist.cpu_clk[6:1]) == 6'b111000);

  always_ff @(posedge CLK2 or negedge arst_n) begin
    if (!arst_n) begin
      rd_end_q    <= 1'b0;
      wr_end_q    <= 1'b0;
      free_strobe <= 1'b0;
    end else begin
      rd_end_q <= ((ctl_hist.read_n[5:0] & ctl_hist.read_n[6:1]) == 6'b000001);
      wr_end_q <= ((ctl_hist.write_n[5:0] & ctl_hist.write_n[6:1]) == 6'b000001);
      // whole cpu cycle is free when it does not touch rom
      if (cycle_start) begin
        free_strobe <= ~rom_hit;
      end else if (cycle_end) begin
        free_strobe <= 1'b0;
      end
    end
  end

  assign strb = '{
    rd_start:    rd_start,
    rd_end:      rd_end_q,
    wr_end:      wr_end_q,
    cycle_start: cycle_start,
    cycle_end:   cycle_end,
    free_slot:   cycle_end | free_strobe
  };

  // --------------------------------------------------
  // dead console watchdog
  // --------------------------------------------------
  always_ff @(posedge CLK2 or negedge arst_n) begin
    if (!arst_n) begin
      dead_cnt  <= '0;
      dead      <= 1'b1;
      cop_reset <= 1'b0;
    end else begin
      cop_reset <= 1'b0;
      if (bus.cpu_clk) begin
        dead_cnt <= '0;
        dead     <= 1'b0;
        // console came back to life
        if (dead) begin
          cop_reset <= 1'b1;
        end
      end else begin
        dead_cnt <= dead_cnt + 18'd1;
        if (dead_cnt > DEAD_TIMEOUT) begin
          dead <= 1'b1;
        end
      end
    end
  end

endmodule

/* design/rom_req_capture.sv */
`timescale 1ns/1ps

module rom_req_capture (
  input  logic                 CLK2,
  input  logic                 arst_n,
  input  logic                 mcu_rrq,
  input  logic                 mcu_wrq,
  input  cart_pkg::snes_addr_t mcu_addr,
  input  logic                 cop_rrq,
  input  logic                 cop_wrq,
  input  logic                 cop_word,
  input  cart_pkg::snes_addr_t cop_addr,
  input  cart_pkg::rom_word_u  cop_wdata,
  input  cart_pkg::arb_state_t arb_state,
  input  logic                 delay_zero,
  output cart_pkg::mem_req_t   mcu_req,
  output cart_pkg::mem_req_t   cop_req,
  output logic                 mcu_rdy,
  output logic                 cop_rdy
);
  import cart_pkg::*;

  logic       mcu_rd_pend;
  logic       mcu_wr_pend;
  logic       cop_rd_pend;
  logic       cop_wr_pend;
  logic       cop_word_q;
  snes_addr_t mcu_addr_q;
  snes_addr_t cop_addr_q;
  rom_word_u  cop_wdata_q;
  logic       mcu_done;
  logic       cop_done;
  logic       cop_early;

  assign mcu_done  = arb_state inside {mcu_rd_end, mcu_wr_end};
  assign cop_done  = arb_state inside {cop_rd_end, cop_wr_end};
  // coprocessor data is already valid on the last addr cycle
  assign cop_early = (arb_state inside {cop_rd_addr, cop_wr_addr}) && delay_zero;

  // --------------------------------------------------
  // pending flags and ready levels
  // --------------------------------------------------
  always_ff @(posedge CLK2 or negedge arst_n) begin
    if (!arst_n) begin
      mcu_rd_pend <= 1'b0;
      mcu_wr_pend <= 1'b0;
      mcu_rdy     <= 1'b1;
    end else if (mcu_rrq) begin
      mcu_rd_pend <= 1'b1;
      mcu_wr_pend <= 1'b0;
      mcu_rdy     <= 1'b0;
    end else if (mcu_wrq) begin
      mcu_rd_pend <= 1'b0;
      mcu_wr_pend <= 1'b1;
      mcu_rdy     <= 1'b0;
    end else if (mcu_done) begin
      mcu_rd_pend <= 1'b0;
      mcu_wr_pend <= 1'b0;
      mcu_rdy     <= 1'b1;
    end
  end

  always_ff @(posedge CLK2 or negedge arst_n) begin
    if (!arst_n) begin
      cop_rd_pend <= 1'b0;
      cop_wr_pend <= 1'b0;
      cop_rdy     <= 1'b1;
    end else if (cop_rrq) begin
      cop_rd_pend <= 1'b1;
      cop_wr_pend <= 1'b0;
      cop_rdy     <= 1'b0;
    end else if (cop_wrq) begin
      cop_rd_pend <= 1'b0;
      cop_wr_pend <= 1'b1;
      cop_rdy     <= 1'b0;
    end else if (cop_early) begin
      cop_rdy <= 1'b1;
    end else if (cop_done) begin
      cop_rd_pend <= 1'b0;
      cop_wr_pend <= 1'b0;
      cop_rdy     <= 1'b1;
    end
  end

  // request payload
  always_ff @(posedge CLK2) begin
    if (mcu_rrq | mcu_wrq) begin
      mcu_addr_q <= mcu_addr;
    end
    if (cop_rrq | cop_wrq) begin
      cop_addr_q <= cop_addr;
      cop_word_q <= cop_word;
    end
    if (cop_wrq) begin
      cop_wdata_q <= cop_wdata;
    end
  end

  // mcu is byte wide, its write byte comes straight from the pins
  assign mcu_req = '{
    rd_pend: mcu_rd_pend,
    wr_pend: mcu_wr_pend,
    word:    1'b0,
    addr:    mcu_addr_q,
    wdata:   '0
  };

  assign cop_req = '{
    rd_pend: cop_rd_pend,
    wr_pend: cop_wr_pend,
    word:    cop_word_q,
    addr:    cop_addr_q,
    wdata:   cop_wdata_q
  };

endmodule

/* design/rom_arbiter.sv */
`timescale 1ns/1ps

module rom_arbiter (
  input  logic                   CLK2,
  input  logic                   arst_n,
  input  cart_pkg::snes_strobe_t strb,
  input  logic                   dead,
  input  cart_pkg::snes_bus_t    bus,
  input  logic                   cop_rrq,
  input  cart_pkg::mem_req_t     mcu_req,
  input  cart_pkg::mem_req_t     cop_req,
  input  cart_pkg::rom_word_u    rom_dq_in,
  input  logic                   lane_odd,
  output cart_pkg::arb_state_t   arb_state,
  output logic                   delay_zero,
  output cart_pkg::byte_t        mcu_rdata,
  output cart_pkg::rom_word_u    cop_rdata
);
  import cart_pkg::*;

  logic [3:0] delay;
  logic       in_addr;
  logic       restart;
  logic       lane_odd_q;

  assign delay_zero = (delay == 4'd0);
  assign in_addr    = arb_state inside {mcu_rd_addr, mcu_wr_addr, cop_rd_addr, cop_wr_addr};

  // console wakes up, abort whatever runs and start over
  assign restart = dead & bus.cpu_clk;

  // --------------------------------------------------
  // access state machine
  // --------------------------------------------------
  always_ff @(posedge CLK2 or negedge arst_n) begin
    if (!arst_n) begin
      arb_state <= idle;
      delay     <= 4'd0;
    end else if (restart) begin
      arb_state <= idle;
    end else begin
      if (in_addr) begin
        delay <= delay - 4'd1;
      end
      case (arb_state)
        idle: begin
          if (strb.free_slot | dead) begin
            // coprocessor read may start on the request cycle itself
            if (cop_req.rd_pend | cop_rrq) begin
              arb_state <= cop_rd_addr;
              delay     <= ROM_CYCLE_LEN;
            end else if (cop_req.wr_pend) begin
              arb_state <= cop_wr_addr;
              delay     <= ROM_CYCLE_LEN;
            end else if (mcu_req.rd_pend) begin
              arb_state <= mcu_rd_addr;
              delay     <= ROM_CYCLE_LEN;
            end else if (mcu_req.wr_pend) begin
              arb_state <= mcu_wr_addr;
              delay     <= ROM_CYCLE_LEN;
            end
          end
        end
        mcu_rd_addr: begin
          if (delay_zero) begin
            arb_state <= mcu_rd_end;
          end
        end
        mcu_wr_addr: begin
          if (delay_zero) begin
            arb_state <= mcu_wr_end;
          end
        end
        cop_rd_addr: begin
          if (delay_zero) begin
            arb_state <= cop_rd_end;
          end
        end
        cop_wr_addr: begin
          if (delay_zero) begin
            arb_state <= cop_wr_end;
          end
        end
        // end states last one cycle
        default: arb_state <= idle;
      endcase
    end
  end

  // --------------------------------------------------
  // read data capture
  // --------------------------------------------------
  always_ff @(posedge CLK2) begin
    lane_odd_q <= lane_odd;
    if (arb_state == mcu_rd_addr) begin
      mcu_rdata <= lane_odd ? rom_dq_in.lane.lo : rom_dq_in.lane.hi;
    end
    // even byte goes to the low half of the word
    if (arb_state == cop_rd_addr) begin
      cop_rdata.word <= lane_odd_q ? rom_dq_in.word
                                   : {rom_dq_in.lane.lo, rom_dq_in.lane.hi};
    end
  end

endmodule

/* design/rom_bus_drive.sv */
`timescale 1ns/1ps

module rom_bus_drive (
  input  logic                 CLK2,
  input  logic                 arst_n,
  input  cart_pkg::snes_bus_t  bus,
  input  cart_pkg::snes_addr_t rom_mask,
  input  cart_pkg::arb_state_t arb_state,
  input  cart_pkg::mem_req_t   mcu_req,
  input  cart_pkg::mem_req_t   cop_req,
  input  cart_pkg::byte_t      mcu_wdata,
  input  cart_pkg::rom_word_u  rom_dq_in,
  output logic                 rom_hit,
  output logic                 lane_odd,
  output cart_pkg::rom_addr_t  rom_addr,
  output cart_pkg::rom_word_u  rom_dq_out,
  output logic                 rom_dq_oe,
  output logic                 rom_we_n,
  output logic                 rom_bhe_n,
  output logic                 rom_ble_n,
  output cart_pkg::byte_t      snes_data_out,
  output logic                 snes_data_oe
);
  import cart_pkg::*;

  logic       mcu_hit;
  logic       cop_hit;
  logic       wr_hit;
  logic       cop_both;
  snes_addr_t snes_rom_addr;
  snes_addr_t sel_addr;
  byte_t      lane_byte;

  assign rom_hit       = ~bus.romsel_n;
  assign snes_rom_addr = bus.addr & rom_mask;

  assign mcu_hit = arb_state inside {mcu_rd_addr, mcu_wr_addr};
  assign cop_hit = arb_state inside {cop_rd_addr, cop_wr_addr};
  assign wr_hit  = arb_state inside {mcu_wr_addr, cop_wr_addr};

  // coprocessor first, then mcu, console otherwise
  assign sel_addr = cop_hit ? cop_req.addr :
                    mcu_hit ? mcu_req.addr : snes_rom_addr;
  assign rom_addr = sel_addr[23:1];
  assign lane_odd = sel_addr[0];

  // --------------------------------------------------
  // write lanes and enables
  // --------------------------------------------------
  always_comb begin
    if (cop_hit) begin
      rom_dq_out.word = lane_odd ? cop_req.wdata.word
                                 : {cop_req.wdata.lane.lo, cop_req.wdata.lane.hi};
    end else begin
      // byte on both lanes, the byte enable picks one
      rom_dq_out.word = {mcu_wdata, mcu_wdata};
    end
  end

  assign rom_dq_oe = wr_hit;
  assign rom_we_n  = ~wr_hit;

  assign cop_both  = cop_hit & cop_req.word;
  assign rom_bhe_n = lane_odd & ~cop_both;
  assign rom_ble_n = ~lane_odd & ~cop_both;

  // --------------------------------------------------
  // console read return
  // --------------------------------------------------
  assign lane_byte = lane_odd ? rom_dq_in.lane.lo : rom_dq_in.lane.hi;

  always_ff @(posedge CLK2 or negedge arst_n) begin
    if (!arst_n) begin
      snes_data_oe <= 1'b0;
    end else begin
      snes_data_oe <= rom_hit & ~bus.read_n & bus.write_n;
    end
  end

  // hold the last console byte while another user owns the memory
  always_ff @(posedge CLK2) begin
    if (!mcu_hit && !cop_hit) begin
      snes_data_out <= lane_byte;
    end
  end

endmodule

/* design/cart_top.sv */
`timescale 1ns/1ps

module cart_top (
  input  logic                 CLK2,
  input  logic                 arst_n,
  input  cart_pkg::snes_addr_t snes_addr_in,
  input  cart_pkg::byte_t      snes_data_in,
  input  logic                 snes_read_n,
  input  logic                 snes_write_n,
  input  logic                 snes_cpu_clk,
  input  logic                 snes_romsel_n,
  input  cart_pkg::snes_addr_t rom_mask,
  input  cart_pkg::rom_word_u  rom_dq_in,
  input  logic                 mcu_rrq,
  input  logic                 mcu_wrq,
  input  cart_pkg::snes_addr_t mcu_addr,
  input  cart_pkg::byte_t      mcu_wdata,
  input  logic                 cop_rrq,
  input  logic                 cop_wrq,
  input  logic                 cop_word,
  input  cart_pkg::snes_addr_t cop_addr,
  input  cart_pkg::rom_word_u  cop_wdata,
  output cart_pkg::byte_t      snes_data_out,
  output logic                 snes_data_oe,
  output cart_pkg::rom_addr_t  rom_addr,
  output cart_pkg::rom_word_u  rom_dq_out,
  output logic                 rom_dq_oe,
  output logic                 rom_we_n,
  output logic                 rom_bhe_n,
  output logic                 rom_ble_n,
  output logic                 mcu_rdy,
  output cart_pkg::byte_t      mcu_rdata,
  output logic                 cop_rdy,
  output cart_pkg::rom_word_u  cop_rdata,
  output logic                 cop_reset
);
  import cart_pkg::*;

  snes_bus_t    bus;
  ctl_hist_t    ctl_hist;
  snes_strobe_t strb;
  logic         dead;
  logic         rom_hit;
  logic         lane_odd;
  logic         delay_zero;
  arb_state_t   arb_state;
  mem_req_t     mcu_req;
  mem_req_t     cop_req;

  // console input sampling
  snes_bus_sync u_sync (
    .CLK2, .arst_n, .snes_addr_in, .snes_data_in, .snes_read_n, .snes_write_n,
    .snes_cpu_clk, .snes_romsel_n, .bus, .ctl_hist
  );

  snes_cycle_detect u_cycle (
    .CLK2, .arst_n, .bus, .ctl_hist, .rom_hit, .strb, .dead, .cop_reset
  );

  rom_req_capture u_req (
    .CLK2, .arst_n, .mcu_rrq, .mcu_wrq, .mcu_addr, .cop_rrq, .cop_wrq, .cop_word,
    .cop_addr, .cop_wdata, .arb_state, .delay_zero, .mcu_req, .cop_req,
    .mcu_rdy, .cop_rdy
  );

  rom_arbiter u_arb (
    .CLK2, .arst_n, .strb, .dead, .bus, .cop_rrq, .mcu_req, .cop_req, .rom_dq_in,
    .lane_odd, .arb_state, .delay_zero, .mcu_rdata, .cop_rdata
  );

  // psram pins and console data return
  rom_bus_drive u_drive (
    .CLK2, .arst_n, .bus, .rom_mask, .arb_state, .mcu_req, .cop_req, .mcu_wdata,
    .rom_dq_in, .rom_hit, .lane_odd, .rom_addr, .rom_dq_out, .rom_dq_oe, .rom_we_n,
    .rom_bhe_n, .rom_ble_n, .snes_data_out, .snes_data_oe
  );

endmodule

/* sim/tb_cart_ref.svh */
`ifndef TB_CART_REF_SVH
`define TB_CART_REF_SVH

// --------------------------------------------------
// reference memory, same word layout as the psram
// --------------------------------------------------

logic [15:0] ref_mem [0:MEM_WORDS-1];

// start contents, the odd multiplier mixes every index bit into the word
function automatic logic [15:0] fill_word(input int idx);
  logic [31:0] prod;
  prod = idx * 32'h0000_9e37;
  return prod[15:0] ^ 16'ha5c3;
endfunction

// even byte lives in the high lane
function automatic byte_t ref_byte(input snes_addr_t a);
  logic [15:0] w;
  w = ref_mem[a[12:1]];
  return a[0] ? w[7:0] : w[15:8];
endfunction

// coprocessor word view, even byte in the low half
function automatic logic [15:0] ref_word(input snes_addr_t a);
  snes_addr_t even_a;
  even_a = {a[23:1], 1'b0};
  return {ref_byte(even_a | 24'd1), ref_byte(even_a)};
endfunction

function automatic void ref_write_byte(input snes_addr_t a, input byte_t d);
  if (a[0]) begin
    ref_mem[a[12:1]][7:0] = d;
  end else begin
    ref_mem[a[12:1]][15:8] = d;
  end
endfunction

function automatic void ref_write_word(input snes_addr_t a, input logic [15:0] d);
  ref_write_byte({a[23:1], 1'b0}, d[7:0]);
  ref_write_byte({a[23:1], 1'b1}, d[15:8]);
endfunction

// --------------------------------------------------
// request side
// --------------------------------------------------

function automatic req_desc_t make_req(input logic wr, input logic word,
                                       input snes_addr_t addr, input logic [15:0] wdata);
  req_desc_t r;
  r.en    = 1'b1;
  r.wr    = wr;
  r.word  = word;
  r.addr  = addr;
  r.wdata = wdata;
  return r;
endfunction

function automatic void push_check(input string name, input logic [15:0] got,
                                   input logic [15:0] exp);
  check_t item;
  item.got = got;
  item.exp = exp;
  check_q.push_back(item);
  name_q.push_back(name);
endfunction

// one pulse per enabled requester, then wait for the ready levels
task automatic run_requests(input req_desc_t m, input req_desc_t c,
                            output int m_cyc, output int c_cyc);
  int cyc;
  m_cyc = 0;
  c_cyc = 0;
  cyc   = 1;
  @(posedge CLK2);
  if (m.en) begin
    mcu_addr  <= m.addr;
    mcu_wdata <= m.wdata[7:0];
    mcu_rrq   <= ~m.wr;
    mcu_wrq   <= m.wr;
  end
  if (c.en) begin
    cop_addr  <= c.addr;
    cop_word  <= c.word;
    cop_wdata <= c.wdata;
    cop_rrq   <= ~c.wr;
    cop_wrq   <= c.wr;
  end
  @(posedge CLK2);
  mcu_rrq <= 1'b0;
  mcu_wrq <= 1'b0;
  cop_rrq <= 1'b0;
  cop_wrq <= 1'b0;
  @(negedge CLK2);
  assert (!(m.en && mcu_rdy)) else begin
    $display("mcu_rdy stayed high after a request to 0x%06h", m.addr);
    proto_errs++;
  end
  assert (!(c.en && cop_rdy)) else begin
    $display("cop_rdy stayed high after a request to 0x%06h", c.addr);
    proto_errs++;
  end
  while (cyc < RDY_LIMIT && ((m.en && m_cyc == 0) || (c.en && c_cyc == 0))) begin
    @(negedge CLK2);
    cyc++;
    if (m.en && m_cyc == 0 && mcu_rdy) begin
      m_cyc = cyc;
    end
    if (c.en && c_cyc == 0 && cop_rdy) begin
      c_cyc = cyc;
    end
  end
  assert (!(m.en && m_cyc == 0)) else begin
    $display("mcu_rdy did not return within %0d cycles", RDY_LIMIT);
    proto_errs++;
  end
  assert (!(c.en && c_cyc == 0)) else begin
    $display("cop_rdy did not return within %0d cycles", RDY_LIMIT);
    proto_errs++;
  end
  if (m.en && m_cyc != 0) begin
    if (m.wr) begin
      ref_write_byte(m.addr, m.wdata[7:0]);
    end else begin
      push_check("mcu_rdata", {8'h00, mcu_rdata}, {8'h00, ref_byte(m.addr)});
    end
  end
  if (c.en && c_cyc != 0) begin
    if (c.wr) begin
      ref_write_word(c.addr, c.wdata);
    end else if (c.word) begin
      push_check("cop_rdata", cop_rdata, ref_word(c.addr));
    end else begin
      push_check("cop_rdata.lo", {8'h00, cop_rdata.lane.lo}, {8'h00, ref_byte(c.addr)});
    end
  end
endtask

`endif

/* sim/tb_cart_top.sv */
`timescale 1ns/1ps

module tb_cart_top;
  import cart_pkg::*;

  localparam int         MEM_WORDS = 4096;
  localparam snes_addr_t ADDR_MASK = 24'h001fff;
  // holes in the console mask so that masking shows in the read data
  localparam snes_addr_t CONSOLE_MASK = 24'h001ef7;
  localparam int         N_B2      = 16;
  localparam int         N_B3      = 8;
  localparam int         N_B4      = 6;
  localparam int         N_B5      = 8;
  localparam int         RDY_LIMIT = 100;
  localparam int         PLANNED   = 2 * N_B2 + 4 * N_B3 + 2 * N_B4 + 2 * N_B5;
  localparam int         WATCHDOG_CYCLES = 20 * PLANNED + int'(DEAD_TIMEOUT) + 1000;

  typedef struct packed {
    logic       en;
    logic       wr;
    logic       word;
    snes_addr_t addr;
    logic [15:0] wdata;
  } req_desc_t;

  typedef struct packed {
    logic [15:0] got;
    logic [15:0] exp;
  } check_t;

  logic       CLK2;
  logic       arst_n;
  snes_addr_t snes_addr_in;
  byte_t      snes_data_in;
  logic       snes_read_n;
  logic       snes_write_n;
  logic       snes_cpu_clk;
  logic       snes_romsel_n;
  snes_addr_t rom_mask;
  rom_word_u  rom_dq_in;
  logic       mcu_rrq;
  logic       mcu_wrq;
  snes_addr_t mcu_addr;
  byte_t      mcu_wdata;
  logic       cop_rrq;
  logic       cop_wrq;
  logic       cop_word;
  snes_addr_t cop_addr;
  rom_word_u  cop_wdata;
  byte_t      snes_data_out;
  logic       snes_data_oe;
  rom_addr_t  rom_addr;
  rom_word_u  rom_dq_out;
  logic       rom_dq_oe;
  logic       rom_we_n;
  logic       rom_bhe_n;
  logic       rom_ble_n;
  logic       mcu_rdy;
  byte_t      mcu_rdata;
  logic       cop_rdy;
  rom_word_u  cop_rdata;
  logic       cop_reset;

  check_t      check_q [$];
  string       name_q [$];
  int          checks_done = 0;
  int          value_errs = 0;
  int          proto_errs = 0;
  int          reset_pulses = 0;
  integer      seed = 32'hc30a1ee2;
  logic        console_on = 1'b0;
  logic [15:0] psram [0:MEM_WORDS-1];

  `include "tb_cart_ref.svh"

  cart_top uut (
    .CLK2, .arst_n, .snes_addr_in, .snes_data_in, .snes_read_n, .snes_write_n,
    .snes_cpu_clk, .snes_romsel_n, .rom_mask, .rom_dq_in, .mcu_rrq, .mcu_wrq,
    .mcu_addr, .mcu_wdata, .cop_rrq, .cop_wrq, .cop_word, .cop_addr, .cop_wdata,
    .snes_data_out, .snes_data_oe, .rom_addr, .rom_dq_out, .rom_dq_oe, .rom_we_n,
    .rom_bhe_n, .rom_ble_n, .mcu_rdy, .mcu_rdata, .cop_rdy, .cop_rdata, .cop_reset
  );

  initial begin
    CLK2 = 1'b0;
    forever #5 CLK2 = ~CLK2;
  end

  // --------------------------------------------------
  // psram model, async read, lane writes on the clock
  // --------------------------------------------------
  initial begin
    for (int i = 0; i < MEM_WORDS; i++) begin
      psram[i]   = fill_word(i);
      ref_mem[i] = fill_word(i);
    end
  end

  assign rom_dq_in = psram[rom_addr[11:0]];

  always @(posedge CLK2) begin
    if (rom_we_n === 1'b0) begin
      if (!rom_bhe_n) begin
        psram[rom_addr[11:0]][15:8] <= rom_dq_out.lane.hi;
      end
      if (!rom_ble_n) begin
        psram[rom_addr[11:0]][7:0] <= rom_dq_out.lane.lo;
      end
    end
  end

  // console cpu clock, 12 CLK2 cycles per period
  initial begin : console_clock
    int phase;
    phase        = 0;
    snes_cpu_clk = 1'b0;
    forever begin
      @(posedge CLK2);
      if (console_on) begin
        snes_cpu_clk <= (phase < 6);
        phase = (phase + 1) % 12;
      end else begin
        snes_cpu_clk <= 1'b0;
      end
    end
  end

  always @(negedge CLK2) begin
    if (cop_reset === 1'b1) begin
      reset_pulses++;
    end
  end

  // --------------------------------------------------
  // compare process
  // --------------------------------------------------
  always @(negedge CLK2) begin : compare
    check_t chk;
    string  name;
    while (check_q.size() > 0) begin
      chk  = check_q.pop_front();
      name = name_q.pop_front();
      checks_done++;
      assert (chk.got === chk.exp) else begin
        $display("CHECK FAILED %s got 0x%0h expected 0x%0h", name, chk.got, chk.exp);
        value_errs++;
      end
    end
  end

  function automatic snes_addr_t rand_addr();
    snes_addr_t a;
    a = $random(seed);
    return a & ADDR_MASK;
  endfunction

  task automatic report_counts();
    $display("checks %0d, value errors %0d, other errors %0d",
             checks_done, value_errs, proto_errs);
  endtask

  initial begin : watchdog
    repeat (WATCHDOG_CYCLES) @(posedge CLK2);
    $display("watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
    report_counts();
    $display("Simulation failed");
    $finish;
  end

  // --------------------------------------------------
  // stimulus
  // --------------------------------------------------
  initial begin : stimulus
    snes_addr_t b2_addr [N_B2];
    byte_t      b2_data [N_B2];
    snes_addr_t b3_addr [N_B3];
    snes_addr_t m_prev;
    snes_addr_t c_prev;
    snes_addr_t a;
    req_desc_t  m;
    req_desc_t  c;
    int         m_cyc;
    int         c_cyc;
    int         pulses_before;

    arst_n        = 1'b0;
    snes_addr_in  = '0;
    snes_data_in  = '0;
    snes_read_n   = 1'b1;
    snes_write_n  = 1'b1;
    snes_romsel_n = 1'b1;
    rom_mask      = CONSOLE_MASK;
    mcu_rrq       = 1'b0;
    mcu_wrq       = 1'b0;
    mcu_addr      = '0;
    mcu_wdata     = '0;
    cop_rrq       = 1'b0;
    cop_wrq       = 1'b0;
    cop_word      = 1'b0;
    cop_addr      = '0;
    cop_wdata     = '0;
    m_prev        = '0;
    c_prev        = '0;
    repeat (4) @(posedge CLK2);
    arst_n <= 1'b1;
    @(negedge CLK2);

    // idle levels right after reset
    push_check("mcu_rdy", mcu_rdy, 1);
    push_check("cop_rdy", cop_rdy, 1);
    push_check("rom_we_n", rom_we_n, 1);
    push_check("rom_dq_oe", rom_dq_oe, 0);
    push_check("snes_data_oe", snes_data_oe, 0);
    push_check("cop_reset", cop_reset, 0);

    // mcu byte writes then reads, console dead
    for (int i = 0; i < N_B2; i++) begin
      b2_addr[i] = rand_addr();
      b2_data[i] = $random(seed);
      run_requests(make_req(1'b1, 1'b0, b2_addr[i], {8'h00, b2_data[i]}), '0, m_cyc, c_cyc);
      push_check("mcu_rdy latency", m_cyc, 11);
    end
    for (int i = 0; i < N_B2; i++) begin
      run_requests(make_req(1'b0, 1'b0, b2_addr[i], '0), '0, m_cyc, c_cyc);
      push_check("mcu_rdy latency", m_cyc, 11);
    end

    // coprocessor words, then reads over mcu data
    for (int i = 0; i < N_B3; i++) begin
      b3_addr[i] = rand_addr() & ~24'd1;
      run_requests('0, make_req(1'b1, 1'b1, b3_addr[i], 16'($random(seed))), m_cyc, c_cyc);
    end
    for (int i = 0; i < N_B3; i++) begin
      run_requests('0, make_req(1'b0, 1'b1, b3_addr[i], '0), m_cyc, c_cyc);
    end
    for (int i = 0; i < N_B3; i++) begin
      run_requests('0, make_req(1'b0, 1'b1, b2_addr[i] & ~24'd1, '0), m_cyc, c_cyc);
      run_requests('0, make_req(1'b0, 1'b0, b2_addr[i] | 24'd1, '0), m_cyc, c_cyc);
    end

    // both requesters on the same edge, disjoint halves of the memory
    for (int i = 0; i < N_B4; i++) begin
      if (i % 2 == 0) begin
        m_prev = rand_addr() & 24'h000fff;
        c_prev = (rand_addr() | 24'h001000) & ~24'd1;
        m = make_req(1'b1, 1'b0, m_prev, 16'($random(seed)));
        c = make_req(1'b1, 1'b1, c_prev, 16'($random(seed)));
      end else begin
        m = make_req(1'b0, 1'b0, m_prev, '0);
        c = make_req(1'b0, 1'b1, c_prev, '0);
      end
      run_requests(m, c, m_cyc, c_cyc);
      push_check("cop_rdy before mcu_rdy", (c_cyc < m_cyc), 1);
    end

    // console running and reading rom
    @(posedge CLK2);
    snes_romsel_n <= 1'b0;
    snes_read_n   <= 1'b0;
    console_on    <= 1'b1;
    repeat (40) @(posedge CLK2);
    @(negedge CLK2);
    push_check("cop_reset pulses at console start", reset_pulses, 1);
    for (int i = 0; i < N_B5; i++) begin
      a = $random(seed);
      @(posedge CLK2);
      snes_addr_in <= a;
      repeat (8) @(posedge CLK2);
      @(negedge CLK2);
      push_check("snes_data_out", {8'h00, snes_data_out}, {8'h00, ref_byte(a & CONSOLE_MASK)});
      push_check("snes_data_oe", snes_data_oe, 1);
      run_requests(make_req(1'b0, 1'b0, rand_addr(), '0), '0, m_cyc, c_cyc);
    end

    // long dead period, then the console clock comes back
    @(posedge CLK2);
    console_on <= 1'b0;
    pulses_before = reset_pulses;
    repeat (int'(DEAD_TIMEOUT) + 32) @(posedge CLK2);
    @(negedge CLK2);
    push_check("cop_reset pulses while console off", reset_pulses - pulses_before, 0);
    pulses_before = reset_pulses;
    @(posedge CLK2);
    console_on <= 1'b1;
    repeat (40) @(posedge CLK2);
    @(negedge CLK2);
    push_check("cop_reset pulses after dead period", reset_pulses - pulses_before, 1);

    while (check_q.size() != 0) begin
      @(negedge CLK2);
    end
    report_counts();
    if (value_errs == 0 && proto_errs == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

/* vlog.f */
+incdir+sim
design/cart_pkg.sv
design/snes_bus_sync.sv
design/snes_cycle_detect.sv
design/rom_req_capture.sv
design/rom_arbiter.sv
design/rom_bus_drive.sv
design/cart_top.sv
sim/tb_cart_top.sv

/* Bender.yml */
package:
  name: cart_rom_ctrl

sources:
  - design/cart_pkg.sv
  - design/snes_bus_sync.sv
  - design/snes_cycle_detect.sv
  - design/rom_req_capture.sv
  - design/rom_arbiter.sv
  - design/rom_bus_drive.sv
  - design/cart_top.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/tb_cart_top.sv
